// ==== shadow_pipe.f ====
+incdir+include
source/shadow_pipe_pkg.sv
source/stage_reg.sv
source/step_controller.sv
source/retire_stage.sv
source/shadow_pipe.sv
bench/shadow_pipe_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Compile and run the shadow pipeline testbench with Verilator

rm -rf obj_dir sim.log

verilator --binary --timing --assert --timescale 1ns/1ns \
    -f shadow_pipe.f --top-module shadow_pipe_tb -o shadow_pipe_sim \
    || { echo "Build failed"; exit 1; }

./obj_dir/shadow_pipe_sim 2>&1 | tee sim.log

grep -q "Done: errors found" sim.log && { echo "Simulation failed, see sim.log"; exit 1; }

grep -q "Done: no errors" sim.log \
    && { echo "Simulation passed"; exit 0; } \
    || { echo "Simulation failed, no result in sim.log"; exit 1; }

// ==== include/shadow_pipe_model.svh ====
`ifndef SHADOW_PIPE_MODEL_SVH
`define SHADOW_PIPE_MODEL_SVH

//////////////////////////////////////////////////
// Reference model state
//////////////////////////////////////////////////

// Acknowledged records not yet retired, oldest first
// Its length is the number of filled stages among fetch, decode and execute
instr_rec_t          model_q[$];
int                  model_fill;
logic [ORDER_W-1:0]  model_order;
logic                model_flush;
logic [IRQ_ID_W-1:0] model_irq_id;
logic                model_retire_pend;
instr_rec_t          model_retire_rec;

// Expected outputs of the current cycle
logic                exp_ack;
logic                exp_flush;
logic                exp_retire_valid;
retire_t             exp_retire;
logic [IRQ_ID_W-1:0] exp_irq_id;

function automatic logic [IRQ_ID_W-1:0] lowest_irq(input logic [IRQ_W-1:0] lines);
    logic [IRQ_ID_W-1:0] id;
    logic                found;
    id    = '0;
    found = 1'b0;
    for (int i = 0; i < IRQ_W; i++) begin
        if (lines[i] && !found) begin
            id    = IRQ_ID_W'(i);
            found = 1'b1;
        end
    end
    return id;
endfunction

// Execute is filled only when all three front stages hold a record
function automatic logic exec_holds_mem();
    return (model_q.size() == FILL_STEPS) && model_q[0].mem_op;
endfunction

task automatic reset_model();
    model_q.delete();
    model_fill        = 0;
    model_order       = '0;
    model_flush       = 1'b0;
    model_irq_id      = '0;
    model_retire_pend = 1'b0;
    model_retire_rec  = '0;
    exp_retire        = '0;
endtask

// One clock cycle: expected outputs now, then the state for the next cycle
task automatic advance_model(input logic retire, input logic [IRQ_W-1:0] irq,
                             input instr_rec_t rec);
    logic decision;
    logic exec_valid;
    exp_flush        = model_flush;
    exp_irq_id       = model_irq_id;
    exp_ack          = !model_flush && ((model_fill < FILL_STEPS) || retire);
    exp_retire_valid = model_retire_pend;
    if (model_retire_pend) begin
        exp_retire.rec   = model_retire_rec;
        exp_retire.order = model_order;
        model_order      = model_order + ORDER_W'(1);
    end
    exec_valid = (model_q.size() == FILL_STEPS);
    // Interrupt only in lockstep, outside a flush and with no memory op in execute
    decision = (irq != '0) && (model_fill == FILL_STEPS) && !model_flush && !exec_holds_mem();

    model_retire_pend = exp_ack && exec_valid;
    if (model_retire_pend) begin
        model_retire_rec = model_q.pop_front();
    end
    if (exp_ack) begin
        model_q.push_back(rec);
    end
    if (model_flush) begin
        model_q.delete();
        model_fill = 0;
    end else if (model_fill < FILL_STEPS) begin
        model_fill = model_fill + 1;
    end
    if (decision) begin
        model_irq_id = lowest_irq(irq);
    end
    model_flush = decision;
endtask

`endif

// ==== bench/shadow_pipe_tb.sv ====
`timescale 1ns/1ns

module shadow_pipe_tb
    import shadow_pipe_pkg::*;
    ();

    typedef enum logic [1:0] {RETIRE_LOW, RETIRE_HIGH, RETIRE_RANDOM} retire_mode_t;
    typedef enum logic [1:0] {IRQ_OFF, IRQ_HOLD, IRQ_RANDOM} irq_mode_t;

    logic                clk           = 1'b0;
    logic                rst_n         = 1'b0;
    instr_rec_t          rec_i         = '0;
    logic                core_retire_i = 1'b0;
    logic [IRQ_W-1:0]    irq_i         = '0;
    logic                fetch_ack_o;
    logic                retire_valid_o;
    retire_t             retire_o;
    logic                irq_taken_o;
    logic [IRQ_ID_W-1:0] irq_id_o;

    // Stimulus controls that the test sequence changes on the falling edge
    retire_mode_t     retire_mode = RETIRE_LOW;
    irq_mode_t        irq_mode    = IRQ_OFF;
    logic [IRQ_W-1:0] irq_hold    = '0;
    logic             force_mem   = 1'b0;
    logic             ack_seen    = 1'b0;
    logic             last_ack    = 1'b0;
    logic [31:0]      next_pc     = 32'h0000_1000;
    integer           seed        = 12671;

    string test_name    = "reset";
    int    errors       = 0;
    int    test_errors  = 0;
    int    tests_run    = 0;
    int    tests_passed = 0;
    int    ack_count    = 0;
    int    retire_count = 0;
    int    flush_count  = 0;

    `include "shadow_pipe_model.svh"

    always #10 clk = ~clk;

    shadow_pipe dut (
        .clk            (clk),
        .rst_n          (rst_n),
        .rec_i          (rec_i),
        .core_retire_i  (core_retire_i),
        .irq_i          (irq_i),
        .fetch_ack_o    (fetch_ack_o),
        .retire_valid_o (retire_valid_o),
        .retire_o       (retire_o),
        .irq_taken_o    (irq_taken_o),
        .irq_id_o       (irq_id_o)
    );

    //////////////////////////////////////////////////
    // Record source and core stimulus
    //////////////////////////////////////////////////

    function automatic instr_rec_t random_record(input logic want_mem);
        instr_rec_t r;
        r.pc       = next_pc;
        r.insn     = $random(seed);
        r.rd_addr  = 5'($random(seed));
        r.rd_wdata = $random(seed);
        r.mem_op   = want_mem || ({$random(seed)} % 3 == 0);
        r.trap     = ({$random(seed)} % 16 == 0);
        next_pc    = next_pc + 32'd4;
        return r;
    endfunction

    function automatic logic [IRQ_W-1:0] random_irq();
        logic [IRQ_W-1:0] lines;
        lines = IRQ_W'($random(seed));
        if (lines == '0) begin
            lines[IRQ_W-1] = 1'b1;
        end
        return lines;
    endfunction

    // New record only once the previous one was acknowledged
    always @(posedge clk) begin
        if (!rst_n || ack_seen) begin
            rec_i <= random_record(force_mem);
        end
        case (retire_mode)
            RETIRE_LOW:  core_retire_i <= 1'b0;
            RETIRE_HIGH: core_retire_i <= 1'b1;
            default:     core_retire_i <= ({$random(seed)} % 2 == 0);
        endcase
        case (irq_mode)
            IRQ_OFF:  irq_i <= '0;
            IRQ_HOLD: irq_i <= irq_hold;
            default:  irq_i <= ({$random(seed)} % 24 == 0) ? random_irq() : '0;
        endcase
    end

    //////////////////////////////////////////////////
    // Compare tasks and bookkeeping
    //////////////////////////////////////////////////

    task automatic compare_retire(input string what, input retire_t expected,
                                  input retire_t actual);
        if (actual !== expected) begin
            errors++;
            test_errors++;
            $display("FAILED %s %s: expected %h actual %h", test_name, what, expected, actual);
        end
    endtask

    task automatic compare_irq_id(input logic [IRQ_ID_W-1:0] expected,
                                  input logic [IRQ_ID_W-1:0] actual);
        if (actual !== expected) begin
            errors++;
            test_errors++;
            $display("FAILED %s irq_id_o: expected %0d actual %0d", test_name, expected, actual);
        end
    endtask

    task automatic compare_flag(input string what, input logic expected, input logic actual);
        if (actual !== expected) begin
            errors++;
            test_errors++;
            $display("FAILED %s %s: expected %b actual %b", test_name, what, expected, actual);
        end
    endtask

    task automatic note_timeout(input string what);
        errors++;
        test_errors++;
        $display("ERROR %s: timed out waiting for %s", test_name, what);
    endtask

    task automatic start_test(input string name);
        test_name   = name;
        test_errors = 0;
    endtask

    task automatic end_test();
        tests_run++;
        if (test_errors == 0) begin
            tests_passed++;
            $display("test %s: passed", test_name);
        end else begin
            $display("test %s: failed with %0d errors", test_name, test_errors);
        end
    endtask

    // Outputs are sampled on the falling edge, halfway between input changes
    task automatic next_cycle();
        @(negedge clk);
        if (rst_n) begin
            advance_model(core_retire_i, irq_i, rec_i);
            compare_flag("fetch_ack_o", exp_ack, fetch_ack_o);
            compare_flag("retire_valid_o", exp_retire_valid, retire_valid_o);
            compare_flag("irq_taken_o", exp_flush, irq_taken_o);
            if (exp_retire_valid) begin
                compare_retire("retire_o", exp_retire, retire_o);
            end
            if (exp_flush) begin
                compare_irq_id(exp_irq_id, irq_id_o);
            end
            if (retire_valid_o && !last_ack) begin
                errors++;
                test_errors++;
                $display("ERROR %s: retirement without a step in the cycle before", test_name);
            end
            last_ack     = fetch_ack_o;
            ack_seen     = fetch_ack_o;
            ack_count    = ack_count + int'(fetch_ack_o);
            retire_count = retire_count + int'(retire_valid_o);
            flush_count  = flush_count + int'(irq_taken_o);
        end
    endtask

    //////////////////////////////////////////////////
    // Test sequence
    //////////////////////////////////////////////////

    initial begin
        int waited;
        int base;

        reset_model();
        repeat (8) @(posedge clk);
        rst_n <= 1'b1;

        // Three free steps with the core idle, then nothing moves
        start_test("fill_after_reset");
        for (int i = 0; i < 12; i++) begin
            next_cycle();
            compare_flag("fill fetch_ack_o", i < FILL_STEPS, fetch_ack_o);
        end
        compare_flag("no retirement during fill", 1'b1, retire_count == 0);
        end_test();

        start_test("lockstep_retire");
        retire_mode = RETIRE_RANDOM;
        waited      = 0;
        while (retire_count < 60 && waited < 2000) begin
            next_cycle();
            waited++;
        end
        if (retire_count < 60) note_timeout("60 retirements");
        end_test();

        // Order count keeps running through several flushes
        start_test("order_across_flush");
        irq_mode = IRQ_RANDOM;
        base     = flush_count;
        waited   = 0;
        while (flush_count < base + 3 && waited < 4000) begin
            next_cycle();
            waited++;
        end
        if (flush_count < base + 3) note_timeout("three interrupts");
        irq_mode = IRQ_OFF;
        base     = retire_count;
        waited   = 0;
        while (retire_count < base + 10 && waited < 500) begin
            next_cycle();
            waited++;
        end
        if (retire_count < base + 10) note_timeout("retirement after flush");
        end_test();

        start_test("irq_flush_refill");
        irq_hold = random_irq();
        irq_mode = IRQ_HOLD;
        base     = flush_count;
        waited   = 0;
        while (flush_count == base && waited < 300) begin
            next_cycle();
            waited++;
        end
        if (flush_count == base) note_timeout("irq_taken_o");
        irq_mode = IRQ_OFF;
        for (int i = 0; i < FILL_STEPS; i++) begin
            next_cycle();
            compare_flag("refill fetch_ack_o", 1'b1, fetch_ack_o);
        end
        base   = retire_count;
        waited = 0;
        while (retire_count == base && waited < 300) begin
            next_cycle();
            waited++;
        end
        if (retire_count == base) note_timeout("retirement after refill");
        end_test();

        // Memory record parked in execute while the core stalls
        start_test("mem_blocks_irq");
        force_mem = 1'b1;
        waited    = 0;
        while (!exec_holds_mem() && waited < 100) begin
            next_cycle();
            waited++;
        end
        if (!exec_holds_mem()) note_timeout("memory record in execute");
        retire_mode = RETIRE_LOW;
        irq_hold    = random_irq();
        irq_mode    = IRQ_HOLD;
        repeat (12) begin
            next_cycle();
            compare_flag("irq_taken_o behind memory op", 1'b0, irq_taken_o);
        end
        force_mem   = 1'b0;
        retire_mode = RETIRE_HIGH;
        base        = flush_count;
        waited      = 0;
        while (flush_count == base && waited < 50) begin
            next_cycle();
            waited++;
        end
        if (flush_count == base) note_timeout("irq_taken_o after memory op moved on");
        irq_mode    = IRQ_OFF;
        retire_mode = RETIRE_RANDOM;
        end_test();

        start_test("backpressure_hold");
        waited = 0;
        while (!(model_fill == FILL_STEPS && !model_flush) && waited < 50) begin
            next_cycle();
            waited++;
        end
        if (model_fill != FILL_STEPS) note_timeout("pipeline fill");
        retire_mode = RETIRE_LOW;
        next_cycle();
        base = ack_count;
        // The last retired record stays on retire_o while the core stalls
        repeat (40) begin
            next_cycle();
            compare_flag("fetch_ack_o under back-pressure", 1'b0, fetch_ack_o);
            compare_retire("held retire_o", exp_retire, retire_o);
        end
        compare_flag("no acknowledge under back-pressure", 1'b1, ack_count == base);
        end_test();

        $display("Summary: %0d tests, %0d passed, %0d failed, %0d errors",
                 tests_run, tests_passed, tests_run - tests_passed, errors);
        if (errors == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

// ==== source/shadow_pipe.sv ====
`timescale 1ns/1ns

module shadow_pipe
    import shadow_pipe_pkg::*;
    (
        input  logic                clk,
        input  logic                rst_n,
        input  instr_rec_t          rec_i,
        input  logic                core_retire_i,
        input  logic [IRQ_W-1:0]    irq_i,
        output logic                fetch_ack_o,
        output logic                retire_valid_o,
        output retire_t             retire_o,
        output logic                irq_taken_o,
        output logic [IRQ_ID_W-1:0] irq_id_o
    );

    logic        step;
    logic        flush;
    pipe_stage_t fetch_in;
    pipe_stage_t fetch_pipe;
    pipe_stage_t decode_pipe;
    pipe_stage_t exec_pipe;

    // Every record from the source enters as valid
    assign fetch_in.rec   = rec_i;
    assign fetch_in.valid = 1'b1;

    //////////////////////////////////////////////////
    // Step and flush control
    //////////////////////////////////////////////////

    step_controller step_ctrl_i (
        .clk           (clk),
        .rst_n         (rst_n),
        .core_retire_i (core_retire_i),
        .irq_i         (irq_i),
        .ex_pipe_i     (exec_pipe),
        .step_o        (step),
        .flush_o       (flush),
        .irq_taken_o   (irq_taken_o),
        .irq_id_o      (irq_id_o)
    );

    // The source advances on each fetch step
    assign fetch_ack_o = step;

    //////////////////////////////////////////////////
    // Stages
    //////////////////////////////////////////////////

    stage_reg fetch_stage_i (
        .clk     (clk),
        .rst_n   (rst_n),
        .step_i  (step),
        .flush_i (flush),
        .pipe_i  (fetch_in),
        .pipe_o  (fetch_pipe)
    );

    stage_reg decode_stage_i (
        .clk     (clk),
        .rst_n   (rst_n),
        .step_i  (step),
        .flush_i (flush),
        .pipe_i  (fetch_pipe),
        .pipe_o  (decode_pipe)
    );

    stage_reg exec_stage_i (
        .clk     (clk),
        .rst_n   (rst_n),
        .step_i  (step),
        .flush_i (flush),
        .pipe_i  (decode_pipe),
        .pipe_o  (exec_pipe)
    );

    retire_stage retire_stage_i (
        .clk            (clk),
        .rst_n          (rst_n),
        .step_i         (step),
        .flush_i        (flush),
        .pipe_i         (exec_pipe),
        .retire_valid_o (retire_valid_o),
        .retire_o       (retire_o)
    );

endmodule

// ==== source/retire_stage.sv ====
`timescale 1ns/1ns

module retire_stage
    import shadow_pipe_pkg::*;
    (
        input  logic        clk,
        input  logic        rst_n,
        input  logic        step_i,
        input  logic        flush_i,
        input  pipe_stage_t pipe_i,
        output logic        retire_valid_o,
        output retire_t     retire_o
    );

    logic               retire_load;
    logic               valid_q;
    logic [ORDER_W-1:0] order_q;
    retire_t            retire_q;

    // A valid record from execute retires on this step
    assign retire_load = step_i && !flush_i && pipe_i.valid;

    //////////////////////////////////////////////////
    // Valid and order count
    //////////////////////////////////////////////////

    // Valid for one cycle only, order survives flushes
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid_q <= 1'b0;
            order_q <= '0;
        end else begin
            valid_q <= retire_load;
            if (retire_load) begin
                order_q <= order_q + ORDER_W'(1);
            end
        end
    end

    // Record holds between retirements
    always_ff @(posedge clk) begin
        if (retire_load) begin
            retire_q.rec   <= pipe_i.rec;
            retire_q.order <= order_q;
        end
    end

    assign retire_valid_o = valid_q;
    assign retire_o       = retire_q;

    //////////////////////////////////////////////////
    // Checks
    //////////////////////////////////////////////////

    property p_valid_needs_step;
        @(posedge clk) disable iff (!rst_n)
            retire_valid_o |=> (!retire_valid_o || $past(step_i));
    endproperty

    a_valid_needs_step : assert property (p_valid_needs_step)
        else $error("retire valid held without a step");

endmodule

// ==== source/step_controller.sv ====
`timescale 1ns/1ns

module step_controller
    import shadow_pipe_pkg::*;
    (
        input  logic                clk,
        input  logic                rst_n,
        input  logic                core_retire_i,
        input  logic [IRQ_W-1:0]    irq_i,
        input  pipe_stage_t         ex_pipe_i,
        output logic                step_o,
        output logic                flush_o,
        output logic                irq_taken_o,
        output logic [IRQ_ID_W-1:0] irq_id_o
    );

    logic [FILL_W-1:0]   fill_count;
    logic                fill_done;
    logic                step;
    logic                flush_q;
    logic                mem_in_ex;
    logic                irq_pending;
    logic                irq_decision;
    logic [IRQ_ID_W-1:0] irq_lowest;
    logic [IRQ_ID_W-1:0] irq_id_q;

    //////////////////////////////////////////////////
    // Fill counter
    //////////////////////////////////////////////////

    // Free steps until fetch, decode and execute are loaded
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            fill_count <= '0;
        end else if (flush_q) begin
            fill_count <= '0;
        end else if (!fill_done) begin
            fill_count <= fill_count + FILL_W'(1);
        end
    end

    assign fill_done = (fill_count == FILL_W'(FILL_STEPS));

    //////////////////////////////////////////////////
    // Step generation
    //////////////////////////////////////////////////

    // Once full, the shell follows the core retirement strobe
    always_comb begin
        if (flush_q) begin
            step = 1'b0;
        end else if (!fill_done) begin
            step = 1'b1;
        end else begin
            step = core_retire_i;
        end
    end

    assign step_o = step;

    //////////////////////////////////////////////////
    // Memory busy
    //////////////////////////////////////////////////

    // A valid load or store in execute is about to reach writeback
    assign mem_in_ex = ex_pipe_i.valid && ex_pipe_i.rec.mem_op;

    //////////////////////////////////////////////////
    // Interrupt decision
    //////////////////////////////////////////////////

    assign irq_pending = |irq_i;

    // Lowest index wins
    always_comb begin
        irq_lowest = '0;
        for (int i = IRQ_W - 1; i >= 0; i--) begin
            if (irq_i[i]) begin
                irq_lowest = IRQ_ID_W'(i);
            end
        end
    end

    // Only while the shell is in lockstep and no memory access is in flight
    assign irq_decision = irq_pending && fill_done && !flush_q && !mem_in_ex;

    //////////////////////////////////////////////////
    // Flush generation
    //////////////////////////////////////////////////

    // Registered decision gives a one cycle flush
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            flush_q  <= 1'b0;
            irq_id_q <= '0;
        end else begin
            flush_q <= irq_decision;
            if (irq_decision) begin
                irq_id_q <= irq_lowest;
            end
        end
    end

    assign flush_o     = flush_q;
    assign irq_taken_o = flush_q;
    assign irq_id_o    = irq_id_q;

    //////////////////////////////////////////////////
    // Checks
    //////////////////////////////////////////////////

    property p_no_step_in_flush;
        @(posedge clk) disable iff (!rst_n)
            !(step_o && flush_o);
    endproperty

    a_no_step_in_flush : assert property (p_no_step_in_flush)
        else $error("step and flush high together");

    // Interrupt never taken across a memory access in execute
    property p_irq_not_after_mem;
        @(posedge clk) disable iff (!rst_n)
            irq_taken_o |-> !$past(mem_in_ex);
    endproperty

    a_irq_not_after_mem : assert property (p_irq_not_after_mem)
        else $error("interrupt taken with a memory operation in execute");

endmodule

// ==== source/stage_reg.sv ====
`timescale 1ns/1ns

module stage_reg
    import shadow_pipe_pkg::*;
    (
        input  logic        clk,
        input  logic        rst_n,
        input  logic        step_i,
        input  logic        flush_i,
        input  pipe_stage_t pipe_i,
        output pipe_stage_t pipe_o
    );

    pipe_stage_t pipe_q;

    //////////////////////////////////////////////////
    // Stage register
    //////////////////////////////////////////////////

    // Flush wins over step, otherwise the stage holds
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pipe_q <= '0;
        end else if (flush_i) begin
            pipe_q <= '0;
        end else if (step_i) begin
            pipe_q <= pipe_i;
        end
    end

    assign pipe_o = pipe_q;

    //////////////////////////////////////////////////
    // Checks
    //////////////////////////////////////////////////

    // Content only moves on a step or a flush of the previous cycle
    property p_change_on_step_or_flush;
        @(posedge clk) disable iff (!rst_n)
            !$stable(pipe_o) |-> $past(step_i || flush_i);
    endproperty

    a_change_on_step_or_flush : assert property (p_change_on_step_or_flush)
        else $error("stage content changed without step or flush");

endmodule

// ==== source/shadow_pipe_pkg.sv ====
package shadow_pipe_pkg;

    //////////////////////////////////////////////////
    // Pipeline constants
    //////////////////////////////////////////////////

    // Stages in the shell: fetch, decode, execute, writeback
    localparam int PIPE_DEPTH = 4;

    // Free steps after reset or flush before lockstep with the core
    localparam int FILL_STEPS = PIPE_DEPTH - 1;
    localparam int FILL_W     = $clog2(FILL_STEPS + 1);

    // Interrupt lines and the width of the taken interrupt id
    localparam int IRQ_W    = 8;
    localparam int IRQ_ID_W = $clog2(IRQ_W);

    // Retirement order count
    localparam int ORDER_W = 16;

    //////////////////////////////////////////////////
    // Record and stage types
    //////////////////////////////////////////////////

    // One record per instruction from the simulator side
    typedef struct packed {
        logic [31:0] pc;
        logic [31:0] insn;
        logic [4:0]  rd_addr;
        logic [31:0] rd_wdata;
        logic        mem_op;
        logic        trap;
    } instr_rec_t;

    // Content of one pipeline stage
    typedef struct packed {
        instr_rec_t rec;
        logic       valid;
    } pipe_stage_t;

    // Retired record stamped with its sequence number
    typedef struct packed {
        instr_rec_t         rec;
        logic [ORDER_W-1:0] order;
    } retire_t;

endpackage
